/* design/mx_block_queue.sv */
// MX block queue: four ordered block entries per lane
// Splits beats into blocks, stores exponents, shifts on slot consume
`timescale 1ns/100ps
`default_nettype none

module mx_block_queue
  import mx_slot_pkg::*;
#(
  parameter int unsigned EXP_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             beat_valid_i,
  input  beat_t            beat_i,
  output logic             beat_ready_o,
  input  logic [EXP_W-1:0] exp_i,
  input  entry_mask_t      exp_wr_i,
  output entry_mask_t      need_o,
  input  logic             consume_i,
  output logic             slot_valid_o,
  output block_t           slot_data_o,
  output logic [EXP_W-1:0] slot_exp_o
);

  localparam int unsigned SLOT    = 0;
  localparam int unsigned UPPER   = 1;
  localparam int unsigned PEND_LO = 2;
  localparam int unsigned PEND_HI = 3;

  // Control state
  entry_mask_t dvalid_q, dvalid_d;
  entry_mask_t evalid_q, evalid_d;
  logic        slot_valid_q, slot_valid_d;

  // Payload
  block_t           data_q [NUM_ENTRIES];
  block_t           data_d [NUM_ENTRIES];
  logic [EXP_W-1:0] exp_q  [NUM_ENTRIES];
  logic [EXP_W-1:0] exp_d  [NUM_ENTRIES];

  logic   primary_free;
  logic   pending_free;
  logic   beat_accept;
  logic   consume_en;
  block_t beat_lower;
  block_t beat_upper;

  assign primary_free = !dvalid_q[SLOT] && !dvalid_q[UPPER];
  assign pending_free = !dvalid_q[PEND_LO] && !dvalid_q[PEND_HI];

  // Ready only looks at registered occupancy
  assign beat_ready_o = primary_free || pending_free;
  assign beat_accept  = beat_valid_i && beat_ready_o;

  assign consume_en = consume_i && slot_valid_q;

  assign beat_lower = beat_i[BLOCK_W-1:0];
  assign beat_upper = beat_i[BEAT_W-1:BLOCK_W];

  // Entries holding a block that still waits for its exponent
  assign need_o = dvalid_q & ~evalid_q;

  assign slot_valid_o = slot_valid_q;
  assign slot_data_o  = data_q[SLOT];
  assign slot_exp_o   = exp_q[SLOT];

  always_comb begin
    dvalid_d = dvalid_q;
    evalid_d = evalid_q;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      data_d[i] = data_q[i];
      exp_d[i]  = exp_q[i];
    end

    // Exponent write into the granted entry
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (exp_wr_i[i]) begin
        evalid_d[i] = 1'b1;
        exp_d[i]    = exp_i;
      end
    end

    // Consume shift, exponents travel with their blocks
    if (consume_en) begin
      if (dvalid_d[UPPER]) begin
        dvalid_d[SLOT]  = 1'b1;
        evalid_d[SLOT]  = evalid_d[UPPER];
        data_d[SLOT]    = data_d[UPPER];
        exp_d[SLOT]     = exp_d[UPPER];
        dvalid_d[UPPER] = 1'b0;
        evalid_d[UPPER] = 1'b0;
      end else if (dvalid_d[PEND_LO]) begin
        dvalid_d[SLOT]    = 1'b1;
        evalid_d[SLOT]    = evalid_d[PEND_LO];
        data_d[SLOT]      = data_d[PEND_LO];
        exp_d[SLOT]       = exp_d[PEND_LO];
        dvalid_d[UPPER]   = dvalid_d[PEND_HI];
        evalid_d[UPPER]   = evalid_d[PEND_HI];
        data_d[UPPER]     = data_d[PEND_HI];
        exp_d[UPPER]      = exp_d[PEND_HI];
        dvalid_d[PEND_LO] = 1'b0;
        evalid_d[PEND_LO] = 1'b0;
        dvalid_d[PEND_HI] = 1'b0;
        evalid_d[PEND_HI] = 1'b0;
      end else begin
        dvalid_d[SLOT] = 1'b0;
        evalid_d[SLOT] = 1'b0;
      end
    end

    // Intake after the shift, so a beat arriving with the last consume
    // lands in slot/upper and order is kept
    if (beat_accept) begin
      if (!dvalid_d[SLOT] && !dvalid_d[UPPER]) begin
        dvalid_d[SLOT]  = 1'b1;
        evalid_d[SLOT]  = 1'b0;
        data_d[SLOT]    = beat_lower;
        dvalid_d[UPPER] = 1'b1;
        evalid_d[UPPER] = 1'b0;
        data_d[UPPER]   = beat_upper;
      end else begin
        dvalid_d[PEND_LO] = 1'b1;
        evalid_d[PEND_LO] = 1'b0;
        data_d[PEND_LO]   = beat_lower;
        dvalid_d[PEND_HI] = 1'b1;
        evalid_d[PEND_HI] = 1'b0;
        data_d[PEND_HI]   = beat_upper;
      end
    end

    slot_valid_d = dvalid_d[SLOT] && evalid_d[SLOT];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dvalid_q     <= '0;
      evalid_q     <= '0;
      slot_valid_q <= 1'b0;
    end else if (clear_i) begin
      dvalid_q     <= '0;
      evalid_q     <= '0;
      slot_valid_q <= 1'b0;
    end else begin
      dvalid_q     <= dvalid_d;
      evalid_q     <= evalid_d;
      slot_valid_q <= slot_valid_d;
    end
  end

  // Payload follows the flags
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      data_q[i] <= data_d[i];
      exp_q[i]  <= exp_d[i];
    end
  end

endmodule : mx_block_queue

`default_nettype wire

/* design/mx_exp_router.sv */
// MX exponent router: grants the lane exponent to the oldest waiting block
`timescale 1ns/100ps
`default_nettype none

module mx_exp_router
  import mx_slot_pkg::*;
(
  input  logic        exp_valid_i,
  input  entry_mask_t need_i,
  input  logic        consume_i,
  output logic        exp_consume_o,
  output entry_mask_t exp_wr_o
);

  logic any_need;

  assign any_need = |need_i;

  // No grant while the slot shifts
  assign exp_consume_o = exp_valid_i && any_need && !consume_i;

  // Lowest index wins, so blocks get exponents in arrival order
  always_comb begin
    exp_wr_o = '0;
    if (exp_consume_o) begin
      for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
        if (need_i[i]) begin
          exp_wr_o    = '0;
          exp_wr_o[i] = 1'b1;
        end
      end
    end
  end

endmodule : mx_exp_router

`default_nettype wire

/* design/mx_slot_buffer.sv */
// MX slot buffer top: X and W operand lanes
// Each lane pairs stream blocks with shared exponents and presents a slot
`timescale 1ns/100ps
`default_nettype none

module mx_slot_buffer
  import mx_slot_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   clear_i,

  // X lane
  input  logic   x_beat_valid_i,
  input  beat_t  x_beat_i,
  output logic   x_beat_ready_o,
  input  logic   x_exp_valid_i,
  input  x_exp_t x_exp_i,
  output logic   x_exp_consume_o,
  output logic   x_slot_valid_o,
  output block_t x_slot_data_o,
  output x_exp_t x_slot_exp_o,
  input  logic   consume_x_slot_i,

  // W lane
  input  logic   w_beat_valid_i,
  input  beat_t  w_beat_i,
  output logic   w_beat_ready_o,
  input  logic   w_exp_valid_i,
  input  w_exp_t w_exp_i,
  output logic   w_exp_consume_o,
  output logic   w_slot_valid_o,
  output block_t w_slot_data_o,
  output w_exp_t w_slot_exp_o,
  input  logic   consume_w_slot_i
);

  entry_mask_t x_need;
  entry_mask_t x_exp_wr;
  entry_mask_t w_need;
  entry_mask_t w_exp_wr;

  mx_block_queue #(
    .EXP_W (X_EXP_W)
  ) u_x_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .beat_valid_i (x_beat_valid_i),
    .beat_i       (x_beat_i),
    .beat_ready_o (x_beat_ready_o),
    .exp_i        (x_exp_i),
    .exp_wr_i     (x_exp_wr),
    .need_o       (x_need),
    .consume_i    (consume_x_slot_i),
    .slot_valid_o (x_slot_valid_o),
    .slot_data_o  (x_slot_data_o),
    .slot_exp_o   (x_slot_exp_o)
  );

  mx_exp_router u_x_router (
    .exp_valid_i   (x_exp_valid_i),
    .need_i        (x_need),
    .consume_i     (consume_x_slot_i),
    .exp_consume_o (x_exp_consume_o),
    .exp_wr_o      (x_exp_wr)
  );

  // W lane carries a full exponent vector per block
  mx_block_queue #(
    .EXP_W (W_EXP_W)
  ) u_w_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .beat_valid_i (w_beat_valid_i),
    .beat_i       (w_beat_i),
    .beat_ready_o (w_beat_ready_o),
    .exp_i        (w_exp_i),
    .exp_wr_i     (w_exp_wr),
    .need_o       (w_need),
    .consume_i    (consume_w_slot_i),
    .slot_valid_o (w_slot_valid_o),
    .slot_data_o  (w_slot_data_o),
    .slot_exp_o   (w_slot_exp_o)
  );

  mx_exp_router u_w_router (
    .exp_valid_i   (w_exp_valid_i),
    .need_i        (w_need),
    .consume_i     (consume_w_slot_i),
    .exp_consume_o (w_exp_consume_o),
    .exp_wr_o      (w_exp_wr)
  );

endmodule : mx_slot_buffer

`default_nettype wire

/* design/mx_slot_pkg.sv */
// MX slot buffer shared widths and types
// Blocks carry four FP8 elements, beats carry two blocks
`default_nettype none

package mx_slot_pkg;

  // Four FP8 elements per block
  localparam int unsigned BLOCK_W = 32;
  localparam int unsigned BEAT_W  = 2 * BLOCK_W;

  // Shared exponent widths per operand lane
  localparam int unsigned X_EXP_W = 8;
  localparam int unsigned W_EXP_W = 32;

  // Slot, upper, pending lower, pending upper
  localparam int unsigned NUM_ENTRIES = 4;

  typedef logic [BLOCK_W-1:0] block_t;

  // Lower block is the older one
  typedef logic [BEAT_W-1:0] beat_t;

  typedef logic [X_EXP_W-1:0] x_exp_t;
  typedef logic [W_EXP_W-1:0] w_exp_t;

  // Index 0 is the slot
  typedef logic [NUM_ENTRIES-1:0] entry_mask_t;

endpackage : mx_slot_pkg

`default_nettype wire

/* mx_slot_buffer.f */
design/mx_slot_pkg.sv
design/mx_block_queue.sv
design/mx_exp_router.sv
design/mx_slot_buffer.sv
testbench/mx_slot_buffer_assert.sv
testbench/tb_mx_slot_buffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MX slot buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mx_slot_buffer.f \
  --top-module tb_mx_slot_buffer -o tb_mx_slot_buffer > build.log 2>&1 \
  && ./obj_dir/tb_mx_slot_buffer > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

/* testbench/mx_slot_buffer_assert.sv */
// MX slot buffer protocol checks
// Exponent handshake, slot stability and ready after clear
`timescale 1ns/100ps
`default_nettype none

module mx_slot_buffer_assert
  import mx_slot_pkg::*;
(
  input wire logic   clk_i,
  input wire logic   rst_ni,
  input wire logic   clear_i,
  input wire logic   x_exp_valid_i,
  input wire logic   x_exp_consume_o,
  input wire logic   x_beat_ready_o,
  input wire logic   x_slot_valid_o,
  input wire block_t x_slot_data_o,
  input wire x_exp_t x_slot_exp_o,
  input wire logic   consume_x_slot_i,
  input wire logic   w_exp_valid_i,
  input wire logic   w_exp_consume_o,
  input wire logic   w_beat_ready_o,
  input wire logic   w_slot_valid_o,
  input wire block_t w_slot_data_o,
  input wire w_exp_t w_slot_exp_o,
  input wire logic   consume_w_slot_i
);

  x_consume_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_exp_consume_o |-> x_exp_valid_i)
    else $error("X exponent consumed without valid");

  w_consume_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_exp_consume_o |-> w_exp_valid_i)
    else $error("W exponent consumed without valid");

  // Slot holds until the arbiter takes it
  x_slot_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    x_slot_valid_o && !consume_x_slot_i && !clear_i |=>
      x_slot_valid_o && $stable(x_slot_data_o) && $stable(x_slot_exp_o))
    else $error("X slot changed without consume");

  w_slot_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_slot_valid_o && !consume_w_slot_i && !clear_i |=>
      w_slot_valid_o && $stable(w_slot_data_o) && $stable(w_slot_exp_o))
    else $error("W slot changed without consume");

  ready_after_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> x_beat_ready_o && w_beat_ready_o)
    else $error("Beat ready low after clear");

endmodule : mx_slot_buffer_assert

bind mx_slot_buffer mx_slot_buffer_assert u_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .clear_i          (clear_i),
  .x_exp_valid_i    (x_exp_valid_i),
  .x_exp_consume_o  (x_exp_consume_o),
  .x_beat_ready_o   (x_beat_ready_o),
  .x_slot_valid_o   (x_slot_valid_o),
  .x_slot_data_o    (x_slot_data_o),
  .x_slot_exp_o     (x_slot_exp_o),
  .consume_x_slot_i (consume_x_slot_i),
  .w_exp_valid_i    (w_exp_valid_i),
  .w_exp_consume_o  (w_exp_consume_o),
  .w_beat_ready_o   (w_beat_ready_o),
  .w_slot_valid_o   (w_slot_valid_o),
  .w_slot_data_o    (w_slot_data_o),
  .w_slot_exp_o     (w_slot_exp_o),
  .consume_w_slot_i (consume_w_slot_i)
);

`default_nettype wire

/* testbench/tb_mx_slot_buffer.sv */
// MX slot buffer testbench
// Table-driven lanes with a block/exponent reference queue per lane
`timescale 1ns/100ps
`default_nettype none

module tb_mx_slot_buffer
  import mx_slot_pkg::*;
();

  localparam int NUM_TESTS = 8;
  localparam int TIMEOUT   = 300;

  logic   clk_i;
  logic   rst_ni;
  logic   clear_i;
  logic   x_beat_valid_i, x_beat_ready_o, x_exp_valid_i, x_exp_consume_o;
  beat_t  x_beat_i;
  x_exp_t x_exp_i, x_slot_exp_o;
  logic   x_slot_valid_o, consume_x_slot_i;
  block_t x_slot_data_o;
  logic   w_beat_valid_i, w_beat_ready_o, w_exp_valid_i, w_exp_consume_o;
  beat_t  w_beat_i;
  w_exp_t w_exp_i, w_slot_exp_o;
  logic   w_slot_valid_o, consume_w_slot_i;
  block_t w_slot_data_o;

  // Lane 0 is X and lane 1 is W
  int     tab_lane [NUM_TESTS] = '{0, 1, 0, 1, 0, 0, 1, 1};
  beat_t  tab_beat [NUM_TESTS] = '{64'h1122_3344_5566_7788, 64'hA1A2_A3A4_B1B2_B3B4,
                                   64'h0F1E_2D3C_4B5A_6978, 64'hC0C1_C2C3_D0D1_D2D3,
                                   64'h8899_AABB_CCDD_EEFF, 64'h1357_9BDF_2468_ACE0,
                                   64'hDEAD_BEEF_CAFE_F00D, 64'h0102_0304_0506_0708};
  w_exp_t tab_e0   [NUM_TESTS] = '{32'h0000_0081, 32'h7F7E_7D7C, 32'h0000_0042,
                                   32'h1020_3040, 32'h0000_00FE, 32'h0000_0003,
                                   32'h5566_7788, 32'hF0E0_D0C0};
  w_exp_t tab_e1   [NUM_TESTS] = '{32'h0000_0077, 32'h0102_0304, 32'h0000_00A5,
                                   32'h5060_7080, 32'h0000_0011, 32'h0000_00C8,
                                   32'h99AA_BBCC, 32'h0B0A_0908};
  // Consume delay per block
  int     tab_hold [NUM_TESTS] = '{0, 2, 12, 0, 1, 14, 10, 0};

  block_t ref_x_data[$];
  x_exp_t ref_x_exp[$];
  block_t ref_w_data[$];
  w_exp_t ref_w_exp[$];
  int     held [2];

  mx_slot_buffer u_dut (.*);

  always #4 clk_i = ~clk_i;

  task automatic report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped on error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    $display("Verification failed");
    $fatal(1, "stopped on mismatch");
  endtask

  task automatic check_block(input block_t got, input block_t exp, input string msg);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", msg, got, exp));
  endtask

  task automatic check_x_exp(input x_exp_t got, input x_exp_t exp, input string msg);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", msg, got, exp));
  endtask

  task automatic check_w_exp(input w_exp_t got, input w_exp_t exp, input string msg);
    if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", msg, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string msg);
    if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", msg, got, exp));
  endtask

  // Blocks pair with exponents in table order with the lower block first
  task automatic build_model();
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (tab_lane[i] == 0) begin
        ref_x_data.push_back(tab_beat[i][BLOCK_W-1:0]);
        ref_x_exp.push_back(tab_e0[i][X_EXP_W-1:0]);
        ref_x_data.push_back(tab_beat[i][BEAT_W-1:BLOCK_W]);
        ref_x_exp.push_back(tab_e1[i][X_EXP_W-1:0]);
      end else begin
        ref_w_data.push_back(tab_beat[i][BLOCK_W-1:0]);
        ref_w_exp.push_back(tab_e0[i]);
        ref_w_data.push_back(tab_beat[i][BEAT_W-1:BLOCK_W]);
        ref_w_exp.push_back(tab_e1[i]);
      end
    end
  endtask

  task automatic send_beat(input int lane, input beat_t beat);
    int   n;
    logic rdy;
    @(posedge clk_i);
    if (lane == 0) begin
      x_beat_valid_i <= 1'b1;
      x_beat_i       <= beat;
    end else begin
      w_beat_valid_i <= 1'b1;
      w_beat_i       <= beat;
    end
    n   = 0;
    rdy = 1'b0;
    while (!rdy) begin
      @(negedge clk_i);
      rdy = (lane == 0) ? x_beat_ready_o : w_beat_ready_o;
      // Ready is high while at most one beat worth of blocks is held
      check_flag(rdy, held[lane] <= 2, $sformatf("lane %0d beat ready", lane));
      n++;
      if (n > TIMEOUT) report_failure($sformatf("lane %0d beat never accepted", lane));
    end
    @(posedge clk_i);
    held[lane] += 2;
    if (lane == 0) x_beat_valid_i <= 1'b0;
    else w_beat_valid_i <= 1'b0;
  endtask

  task automatic send_exp(input int lane, input w_exp_t e);
    int   n;
    logic taken;
    @(posedge clk_i);
    if (lane == 0) begin
      x_exp_valid_i <= 1'b1;
      x_exp_i       <= e[X_EXP_W-1:0];
    end else begin
      w_exp_valid_i <= 1'b1;
      w_exp_i       <= e;
    end
    n     = 0;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = (lane == 0) ? x_exp_consume_o : w_exp_consume_o;
      n++;
      if (n > TIMEOUT) report_failure($sformatf("lane %0d exponent never taken", lane));
    end
    @(posedge clk_i);
    if (lane == 0) x_exp_valid_i <= 1'b0;
    else w_exp_valid_i <= 1'b0;
  endtask

  task automatic slot_compare(input int lane, input block_t data, input w_exp_t e);
    if (lane == 0) begin
      check_flag(x_slot_valid_o, 1'b1, "X slot valid");
      check_block(x_slot_data_o, data, "X slot data");
      check_x_exp(x_slot_exp_o, e[X_EXP_W-1:0], "X slot exponent");
    end else begin
      check_flag(w_slot_valid_o, 1'b1, "W slot valid");
      check_block(w_slot_data_o, data, "W slot data");
      check_w_exp(w_slot_exp_o, e, "W slot exponent");
    end
  endtask

  task automatic expect_slot(input int lane, input block_t data, input w_exp_t e,
                             input int hold, input bit take);
    int   n;
    logic vld;
    n   = 0;
    vld = 1'b0;
    while (!vld) begin
      @(negedge clk_i);
      vld = (lane == 0) ? x_slot_valid_o : w_slot_valid_o;
      n++;
      if (n > TIMEOUT) report_failure($sformatf("lane %0d slot never became valid", lane));
    end
    slot_compare(lane, data, e);
    // Slot must hold while not consumed
    repeat (hold) begin
      @(negedge clk_i);
      slot_compare(lane, data, e);
    end
    if (take) begin
      @(posedge clk_i);
      if (lane == 0) consume_x_slot_i <= 1'b1;
      else consume_w_slot_i <= 1'b1;
      @(posedge clk_i);
      held[lane] -= 1;
      if (lane == 0) consume_x_slot_i <= 1'b0;
      else consume_w_slot_i <= 1'b0;
    end
  endtask

  task automatic run_lane(input int lane);
    fork
      for (int i = 0; i < NUM_TESTS; i++) begin
        if (tab_lane[i] == lane) begin
          repeat ($urandom_range(0, 3)) @(posedge clk_i);
          send_beat(lane, tab_beat[i]);
        end
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
        if (tab_lane[i] == lane) begin
          // Entry 0 takes over the early X exponent without a gap
          if (i > 0) begin
            repeat ($urandom_range(0, 4)) @(posedge clk_i);
          end
          send_exp(lane, tab_e0[i]);
          send_exp(lane, tab_e1[i]);
        end
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
        if (tab_lane[i] == lane) begin
          for (int b = 0; b < 2; b++) begin
            if (lane == 0) expect_slot(0, ref_x_data.pop_front(), 32'(ref_x_exp.pop_front()),
                                       tab_hold[i] + $urandom_range(0, 2), 1'b1);
            else expect_slot(1, ref_w_data.pop_front(), ref_w_exp.pop_front(),
                             tab_hold[i] + $urandom_range(0, 2), 1'b1);
          end
        end
      end
    join
  endtask

  initial begin
    void'($urandom(32'h5306_a063));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    x_beat_valid_i = 1'b0;
    x_beat_i = '0;
    x_exp_valid_i = 1'b0;
    x_exp_i = '0;
    consume_x_slot_i = 1'b0;
    w_beat_valid_i = 1'b0;
    w_beat_i = '0;
    w_exp_valid_i = 1'b0;
    w_exp_i = '0;
    consume_w_slot_i = 1'b0;
    held[0] = 0;
    held[1] = 0;
    build_model();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(negedge clk_i);
    check_flag(x_slot_valid_o, 1'b0, "X slot valid after reset");
    check_flag(w_slot_valid_o, 1'b0, "W slot valid after reset");
    check_flag(x_exp_consume_o, 1'b0, "X exponent consume after reset");
    check_flag(w_exp_consume_o, 1'b0, "W exponent consume after reset");
    check_flag(x_beat_ready_o, 1'b1, "X ready after reset");
    check_flag(w_beat_ready_o, 1'b1, "W ready after reset");

    // Early exponent waits while no block is stored
    @(posedge clk_i);
    x_exp_valid_i <= 1'b1;
    x_exp_i       <= tab_e0[0][X_EXP_W-1:0];
    repeat (4) begin
      @(negedge clk_i);
      check_flag(x_exp_consume_o, 1'b0, "X early exponent consume");
    end

    fork
      run_lane(0);
      run_lane(1);
    join

    // Both lanes full before the clear
    send_beat(0, 64'h2222_2222_1111_1111);
    send_beat(0, 64'h6666_6666_5555_5555);
    send_beat(1, 64'h8888_8888_7777_7777);
    send_beat(1, 64'hAAAA_AAAA_9999_9999);
    send_exp(0, 32'h0000_0033);
    expect_slot(0, 32'h1111_1111, 32'h0000_0033, 2, 1'b0);
    check_flag(x_beat_ready_o, 1'b0, "X ready before clear");
    check_flag(w_beat_ready_o, 1'b0, "W ready before clear");
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    held[0] = 0;
    held[1] = 0;
    @(negedge clk_i);
    check_flag(x_slot_valid_o, 1'b0, "X slot valid after clear");
    check_flag(x_beat_ready_o, 1'b1, "X ready after clear");
    check_flag(w_beat_ready_o, 1'b1, "W ready after clear");

    // Pairing restarts after the clear
    send_beat(0, 64'h4444_4444_3333_3333);
    send_exp(0, 32'h0000_0055);
    expect_slot(0, 32'h3333_3333, 32'h0000_0055, 1, 1'b1);
    send_exp(0, 32'h0000_0066);
    expect_slot(0, 32'h4444_4444, 32'h0000_0066, 0, 1'b1);

    repeat (4) @(posedge clk_i);
    $display("Verification passed");
    $finish;
  end

endmodule : tb_mx_slot_buffer

`default_nettype wire
